/* io_pred_cfg.svh */
// I/O predication configuration
// Address width, port counts and port base addresses shared by the design
// and the testbench

`ifndef IO_PRED_CFG_SVH
`define IO_PRED_CFG_SVH

// Width of one operand address from the instruction
`define IO_ADDR_WIDTH           10

// Number of memory-mapped ports on each side
`define IO_READ_PORT_COUNT      8
`define IO_WRITE_PORT_COUNT     8

// Index width inside one port range, log2 of the port count
`define IO_PORT_INDEX_WIDTH     3

// First port address of each range
// Both bases are aligned to the port count, so the low address bits are
// the port number and the upper bits alone identify the range
`define IO_READ_PORT_BASE       10'h3F8
`define IO_WRITE_PORT_BASE      10'h3F8

`endif

/* io_pred_pkg.sv */
// I/O predication types
// Address, flag vector and port index types built from the configuration

package io_pred_pkg;

`include "io_pred_cfg.svh"

    // ----------------------------------------
    // Operand addresses
    // ----------------------------------------

    // One operand address, read A, read B or write D
    typedef logic [`IO_ADDR_WIDTH-1:0] io_addr_t;

    // ----------------------------------------
    // Port flags
    // ----------------------------------------

    // One empty/full flag per port
    // Read and write ranges have the same number of ports, so one type
    // serves both sides
    typedef logic [`IO_READ_PORT_COUNT-1:0] io_flags_t;

    // Port number within one range, taken from the low address bits
    typedef logic [`IO_PORT_INDEX_WIDTH-1:0] io_port_index_t;

endpackage

/* io_port_check.sv */
// I/O port check
// Decodes whether an operand address falls in a port range and, two stages
// later, whether the addressed port is not ready

module io_port_check
    import io_pred_pkg::*;
#(
    // Flag value that means the port can be accessed
    // Read ports are ready when full (1), write ports when not full (0)
    parameter logic     ready_state = 1'b1,
    // First address of the port range
    parameter io_addr_t port_base   = '0
)(
    input  logic      clock,
    input  logic      reset,
    input  io_addr_t  addr,
    input  io_flags_t flags,
    output logic      addr_is_io_stage_2,
    output logic      port_busy
);

    localparam int addr_width  = $bits(io_addr_t);
    localparam int index_width = $bits(io_port_index_t);

    // ----------------------------------------
    // Address decode
    // ----------------------------------------

    logic           addr_hit;
    io_port_index_t port_index;

    // The base is aligned to the port count, so only the upper bits
    // have to match the base for the address to hit the range
    assign addr_hit = (addr[addr_width-1:index_width] == port_base[addr_width-1:index_width]);

    // The low bits then pick one port inside the range
    assign port_index = addr[index_width-1:0];

    // ----------------------------------------
    // Stage 1
    // ----------------------------------------

    logic addr_is_io_stage_1;
    logic port_flag_stage_1;

    // Capture the hit and the flag of the addressed port on the same edge
    // as the address, so the flag belongs to this instruction
    always_ff @(posedge clock) begin
        if (reset) begin
            addr_is_io_stage_1 <= 1'b0;
            port_flag_stage_1  <= 1'b0;
        end else begin
            addr_is_io_stage_1 <= addr_hit;
            port_flag_stage_1  <= flags[port_index];
        end
    end

    // ----------------------------------------
    // Stage 2
    // ----------------------------------------

    // A port is busy only if it was actually addressed and its flag is
    // not in the ready state
    // Non-I/O addresses never report busy, whatever the flag says
    always_ff @(posedge clock) begin
        if (reset) begin
            port_busy          <= 1'b0;
            addr_is_io_stage_2 <= 1'b0;
        end else begin
            port_busy          <= addr_is_io_stage_1 && (port_flag_stage_1 != ready_state);
            addr_is_io_stage_2 <= addr_is_io_stage_1;
        end
    end

endmodule

/* io_read_predication.sv */
// I/O read predication
// Checks both read operands against the read ports and annuls their read
// enables when the instruction is not ready

`include "io_pred_cfg.svh"

module io_read_predication
    import io_pred_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  io_addr_t  read_addr_a,
    input  io_addr_t  read_addr_b,
    input  io_flags_t read_flags,
    input  logic      io_ready,
    output logic      read_busy,
    output logic      read_enable_a,
    output logic      read_enable_b
);

    // ----------------------------------------
    // Port checks for A and B
    // ----------------------------------------

    logic addr_is_io_a;
    logic addr_is_io_b;
    logic port_busy_a;
    logic port_busy_b;

    // Read ports are ready when full
    io_port_check #(
        .ready_state (1'b1),
        .port_base   (`IO_READ_PORT_BASE)
    ) check_a (
        .clock              (clock),
        .reset              (reset),
        .addr               (read_addr_a),
        .flags              (read_flags),
        .addr_is_io_stage_2 (addr_is_io_a),
        .port_busy          (port_busy_a)
    );

    io_port_check #(
        .ready_state (1'b1),
        .port_base   (`IO_READ_PORT_BASE)
    ) check_b (
        .clock              (clock),
        .reset              (reset),
        .addr               (read_addr_b),
        .flags              (read_flags),
        .addr_is_io_stage_2 (addr_is_io_b),
        .port_busy          (port_busy_b)
    );

    // Either operand waiting on an empty port stalls the whole instruction
    // If A and B hit the same port both checks agree, which is harmless
    assign read_busy = port_busy_a | port_busy_b;

    // ----------------------------------------
    // Annulment
    // ----------------------------------------

    logic addr_is_io_a_stage_3;
    logic addr_is_io_b_stage_3;

    // io_ready for this instruction only exists one stage after the checks,
    // so the hit bits wait here for it
    always_ff @(posedge clock) begin
        if (reset) begin
            addr_is_io_a_stage_3 <= 1'b0;
            addr_is_io_b_stage_3 <= 1'b0;
        end else begin
            addr_is_io_a_stage_3 <= addr_is_io_a;
            addr_is_io_b_stage_3 <= addr_is_io_b;
        end
    end

    // A read enable only survives if every accessed port is ready
    // An annulled read leaves the port FIFO untouched
    assign read_enable_a = addr_is_io_a_stage_3 & io_ready;
    assign read_enable_b = addr_is_io_b_stage_3 & io_ready;

endmodule

/* io_write_predication.sv */
// I/O write predication
// Checks the write operand against the write ports and annuls the write
// enable when the instruction is not ready

`include "io_pred_cfg.svh"

module io_write_predication
    import io_pred_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  io_addr_t  write_addr,
    input  io_flags_t write_flags,
    input  logic      io_ready,
    output logic      write_busy,
    output logic      write_enable
);

    // ----------------------------------------
    // Port check for D
    // ----------------------------------------

    logic addr_is_io_d;

    // A write port flag of 1 means full, so ready is 0 here
    io_port_check #(
        .ready_state (1'b0),
        .port_base   (`IO_WRITE_PORT_BASE)
    ) check_d (
        .clock              (clock),
        .reset              (reset),
        .addr               (write_addr),
        .flags              (write_flags),
        .addr_is_io_stage_2 (addr_is_io_d),
        .port_busy          (write_busy)
    );

    // ----------------------------------------
    // Annulment
    // ----------------------------------------

    logic addr_is_io_d_stage_3;

    // Hold the hit one stage past the check to line it up with io_ready
    always_ff @(posedge clock) begin
        if (reset) begin
            addr_is_io_d_stage_3 <= 1'b0;
        end else begin
            addr_is_io_d_stage_3 <= addr_is_io_d;
        end
    end

    // No write reaches a port for an annulled instruction, so no data is
    // pushed into a FIFO that the re-issued instruction will write again
    assign write_enable = addr_is_io_d_stage_3 & io_ready;

endmodule

/* io_ready_combiner.sv */
// I/O ready combiner
// Delays valid alongside the port checks and merges the read and write
// busy results into one registered io_ready level

module io_ready_combiner (
    input  logic clock,
    input  logic reset,
    input  logic valid,
    input  logic read_busy,
    input  logic write_busy,
    output logic io_ready
);

    // ----------------------------------------
    // Valid delay line
    // ----------------------------------------

    logic valid_stage_1;
    logic valid_stage_2;

    // Two stages, matching the two stages inside each port check, so
    // valid_stage_2 and the busy inputs describe the same instruction
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_stage_1 <= 1'b0;
            valid_stage_2 <= 1'b0;
        end else begin
            valid_stage_1 <= valid;
            valid_stage_2 <= valid_stage_1;
        end
    end

    // ----------------------------------------
    // Ready merge
    // ----------------------------------------

    // The instruction may proceed only if it is real and no accessed port
    // on either side is busy
    // A bubble gives io_ready low, which also keeps every enable low
    always_ff @(posedge clock) begin
        if (reset) begin
            io_ready <= 1'b0;
        end else begin
            io_ready <= valid_stage_2 & ~read_busy & ~write_busy;
        end
    end

endmodule

/* io_predication_top.sv */
// I/O predication subsystem
// Decides per instruction whether all accessed I/O ports are ready and
// annuls the port enables of instructions that are not

module io_predication_top
    import io_pred_pkg::*;
(
    input  logic      clock,
    input  logic      reset,

    // Instruction operands, all sampled on the same edge
    input  logic      valid,
    input  io_addr_t  read_addr_a,
    input  io_addr_t  read_addr_b,
    input  io_addr_t  write_addr,

    // Read flag 1 means full and ready, write flag 1 means full and not ready
    input  io_flags_t read_flags,
    input  io_flags_t write_flags,

    // Results for the instruction three edges later
    output logic      io_ready,
    output logic      read_enable_a,
    output logic      read_enable_b,
    output logic      write_enable
);

    // ----------------------------------------
    // Busy results at stage 2
    // ----------------------------------------

    logic read_busy;
    logic write_busy;

    // ----------------------------------------
    // Read side
    // ----------------------------------------

    io_read_predication read_predication (
        .clock         (clock),
        .reset         (reset),
        .read_addr_a   (read_addr_a),
        .read_addr_b   (read_addr_b),
        .read_flags    (read_flags),
        .io_ready      (io_ready),
        .read_busy     (read_busy),
        .read_enable_a (read_enable_a),
        .read_enable_b (read_enable_b)
    );

    // ----------------------------------------
    // Write side
    // ----------------------------------------

    io_write_predication write_predication (
        .clock        (clock),
        .reset        (reset),
        .write_addr   (write_addr),
        .write_flags  (write_flags),
        .io_ready     (io_ready),
        .write_busy   (write_busy),
        .write_enable (write_enable)
    );

    // ----------------------------------------
    // Ready decision
    // ----------------------------------------

    // io_ready feeds straight back into both predication blocks in the
    // same cycle to gate their enables
    io_ready_combiner ready_combiner (
        .clock      (clock),
        .reset      (reset),
        .valid      (valid),
        .read_busy  (read_busy),
        .write_busy (write_busy),
        .io_ready   (io_ready)
    );

endmodule

/* io_predication_props.sv */
// I/O predication properties
// Concurrent assertions on the top level outputs, bound into the design

module io_predication_props (
    input logic clock,
    input logic reset,
    input logic valid,
    input logic io_ready,
    input logic read_enable_a,
    input logic read_enable_b,
    input logic write_enable
);

    logic any_enable;

    assign any_enable = read_enable_a | read_enable_b | write_enable;

    // Every enable belongs to an instruction that was valid three cycles
    // earlier and was allowed to proceed
    enable_needs_ready: assert property (
        @(posedge clock) disable iff (reset) any_enable |-> io_ready && $past(valid, 3)
    ) else $error("A port enable is high without io_ready or a valid instruction");

    // Nothing is in flight for the first three edges after reset
    quiet_after_reset: assert property (
        @(posedge clock) $fell(reset) |-> (!io_ready && !any_enable) [*3]
    ) else $error("An output went high within three cycles of reset");

endmodule

bind io_predication_top io_predication_props props (
    .clock         (clock),
    .reset         (reset),
    .valid         (valid),
    .io_ready      (io_ready),
    .read_enable_a (read_enable_a),
    .read_enable_b (read_enable_b),
    .write_enable  (write_enable)
);

/* io_predication_checker.sv */
// I/O predication checker
// Predicts io_ready and the port enables of each sampled instruction and
// compares them with the DUT outputs once the instruction comes out

`include "io_pred_cfg.svh"

module io_predication_checker (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            valid,
    input  logic [`IO_ADDR_WIDTH-1:0]       read_addr_a,
    input  logic [`IO_ADDR_WIDTH-1:0]       read_addr_b,
    input  logic [`IO_ADDR_WIDTH-1:0]       write_addr,
    input  logic [`IO_READ_PORT_COUNT-1:0]  read_flags,
    input  logic [`IO_WRITE_PORT_COUNT-1:0] write_flags,
    input  logic                            io_ready,
    input  logic                            read_enable_a,
    input  logic                            read_enable_b,
    input  logic                            write_enable,
    output int                              error_count,
    output int                              check_count
);

    // Inputs are sampled on the falling edge in the middle of their cycle,
    // so the result shows up three falling edges later, one per register stage
    localparam int pipeline_depth = 3;

    int         errors = 0;
    int         checks = 0;
    logic [3:0] expected_queue[$];

    assign error_count = errors;
    assign check_count = checks;

    function automatic logic in_range(input logic [`IO_ADDR_WIDTH-1:0] addr,
                                      input int base, input int count);
        return (int'(addr) >= base) && (int'(addr) < base + count);
    endfunction

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    // Result packed as {io_ready, read_enable_a, read_enable_b, write_enable}
    function automatic logic [3:0] expected_outputs(
        input logic v, input logic [`IO_ADDR_WIDTH-1:0] a, input logic [`IO_ADDR_WIDTH-1:0] b,
        input logic [`IO_ADDR_WIDTH-1:0] d, input logic [`IO_READ_PORT_COUNT-1:0] rf,
        input logic [`IO_WRITE_PORT_COUNT-1:0] wf);
        logic hit_a;
        logic hit_b;
        logic hit_d;
        logic busy;
        logic ready;
        hit_a = in_range(a, `IO_READ_PORT_BASE, `IO_READ_PORT_COUNT);
        hit_b = in_range(b, `IO_READ_PORT_BASE, `IO_READ_PORT_COUNT);
        hit_d = in_range(d, `IO_WRITE_PORT_BASE, `IO_WRITE_PORT_COUNT);
        // A read port must be full, a write port must not be
        busy = (hit_a && !rf[int'(a) - `IO_READ_PORT_BASE])
            || (hit_b && !rf[int'(b) - `IO_READ_PORT_BASE])
            || (hit_d && wf[int'(d) - `IO_WRITE_PORT_BASE]);
        ready = v && !busy;
        return {ready, hit_a && ready, hit_b && ready, hit_d && ready};
    endfunction

    task automatic compare_signal(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED %s at time %0t: expected %h, got %h", name, $time, expected, actual);
            errors++;
        end
    endtask

    // ----------------------------------------
    // Compare on the falling edge
    // ----------------------------------------

    always @(negedge clock) begin : compare_outputs
        logic [3:0] head;
        if (expected_queue.size() == pipeline_depth) begin
            head = expected_queue.pop_front();
            compare_signal("io_ready", head[3], io_ready);
            compare_signal("read_enable_a", head[2], read_enable_a);
            compare_signal("read_enable_b", head[1], read_enable_b);
            compare_signal("write_enable", head[0], write_enable);
            checks++;
        end
        // A reset edge wipes every instruction in flight, so all the
        // pending results become zero
        if (reset) begin
            expected_queue.delete();
            for (int i = 0; i < pipeline_depth; i++) begin
                expected_queue.push_back(4'b0000);
            end
        end else begin
            expected_queue.push_back(expected_outputs(valid, read_addr_a, read_addr_b,
                                                      write_addr, read_flags, write_flags));
        end
    end

endmodule

/* io_predication_tb.sv */
// I/O predication testbench
// Drives reset, directed and LCG random instructions into the subsystem,
// guards the run with a watchdog and prints the final report

`include "io_pred_cfg.svh"

module io_predication_tb;

    // Lengths of the test phases in clock cycles
    localparam int reset_cycles    = 3;
    localparam int idle_cycles     = 6;
    localparam int non_io_cycles   = 24;
    localparam int directed_cycles = 8;
    localparam int random_cycles   = 500;
    localparam int drain_cycles    = 6;
    localparam int test_cycles     = reset_cycles + idle_cycles + non_io_cycles
                                   + directed_cycles + random_cycles + drain_cycles;

    localparam logic [`IO_ADDR_WIDTH-1:0] read_base  = `IO_READ_PORT_BASE;
    localparam logic [`IO_ADDR_WIDTH-1:0] write_base = `IO_WRITE_PORT_BASE;

    logic                            clock;
    logic                            reset;
    logic                            valid;
    logic [`IO_ADDR_WIDTH-1:0]       read_addr_a;
    logic [`IO_ADDR_WIDTH-1:0]       read_addr_b;
    logic [`IO_ADDR_WIDTH-1:0]       write_addr;
    logic [`IO_READ_PORT_COUNT-1:0]  read_flags;
    logic [`IO_WRITE_PORT_COUNT-1:0] write_flags;
    logic                            io_ready;
    logic                            read_enable_a;
    logic                            read_enable_b;
    logic                            write_enable;
    int                              error_count;
    int                              check_count;
    logic [31:0]                     lcg_state;

    io_predication_top uut (
        .clock         (clock),
        .reset         (reset),
        .valid         (valid),
        .read_addr_a   (read_addr_a),
        .read_addr_b   (read_addr_b),
        .write_addr    (write_addr),
        .read_flags    (read_flags),
        .write_flags   (write_flags),
        .io_ready      (io_ready),
        .read_enable_a (read_enable_a),
        .read_enable_b (read_enable_b),
        .write_enable  (write_enable)
    );

    // The checker sees the same ports as the DUT and keeps the counts
    io_predication_checker output_checker (
        .clock         (clock),
        .reset         (reset),
        .valid         (valid),
        .read_addr_a   (read_addr_a),
        .read_addr_b   (read_addr_b),
        .write_addr    (write_addr),
        .read_flags    (read_flags),
        .write_flags   (write_flags),
        .io_ready      (io_ready),
        .read_enable_a (read_enable_a),
        .read_enable_b (read_enable_b),
        .write_enable  (write_enable),
        .error_count   (error_count),
        .check_count   (check_count)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Advance the generator; the upper bits are the better ones
    task automatic draw_random(output logic [31:0] value);
        lcg_state = lcg_next(lcg_state);
        value     = lcg_state;
    endtask

    // About half the addresses land inside the port range
    function automatic logic [`IO_ADDR_WIDTH-1:0] pick_address(
        input logic [31:0] r, input logic [`IO_ADDR_WIDTH-1:0] base);
        if (r[31]) begin
            return base + r[18:16];
        end
        return r[25:16];
    endfunction

    // One instruction per cycle, applied just after the rising edge
    task automatic drive_instruction(
        input logic v, input logic [`IO_ADDR_WIDTH-1:0] a, input logic [`IO_ADDR_WIDTH-1:0] b,
        input logic [`IO_ADDR_WIDTH-1:0] d, input logic [7:0] rf, input logic [7:0] wf);
        @(posedge clock);
        #1;
        valid       = v;
        read_addr_a = a;
        read_addr_b = b;
        write_addr  = d;
        read_flags  = rf;
        write_flags = wf;
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin
        logic [31:0] r_ctrl;
        logic [31:0] r_a;
        logic [31:0] r_b;
        logic [31:0] r_d;
        logic [31:0] r_flags;

        lcg_state   = 32'd20395;
        reset       = 1'b1;
        valid       = 1'b0;
        read_addr_a = '0;
        read_addr_b = '0;
        write_addr  = '0;
        read_flags  = '0;
        write_flags = '0;
        repeat (reset_cycles) @(posedge clock);
        #1;
        reset = 1'b0;

        // Bubbles only, so the outputs must stay low
        repeat (idle_cycles) drive_instruction(1'b0, '0, '0, '0, 8'h00, 8'h00);

        // Addresses below 0x200 never reach a port, whatever the flags
        repeat (non_io_cycles) begin
            draw_random(r_ctrl);
            draw_random(r_flags);
            drive_instruction(r_ctrl[30], {1'b0, r_ctrl[24:16]}, {1'b0, r_ctrl[31:23]},
                              {1'b0, r_flags[8:0]}, r_flags[23:16], r_flags[31:24]);
        end

        // Empty read port on A, then on B, then a full write port
        drive_instruction(1'b1, read_base + 2, 10'h015, 10'h021, 8'hFB, 8'h00);
        drive_instruction(1'b1, read_base + 1, read_base + 5, 10'h021, 8'hDF, 8'h00);
        drive_instruction(1'b1, read_base + 0, 10'h015, write_base + 3, 8'hFF, 8'h08);
        // All ready, with A and B on the same port
        drive_instruction(1'b1, read_base + 4, read_base + 4, write_base + 6, 8'h10, 8'hBF);
        drive_instruction(1'b1, read_base + 7, 10'h1F0, 10'h0C3, 8'h80, 8'hFF);
        drive_instruction(1'b1, 10'h3F0, 10'h1F0, write_base + 0, 8'h00, 8'hFE);
        // Flags all unready but no operand in range
        drive_instruction(1'b1, 10'h3F7, 10'h000, 10'h3F0, 8'h00, 8'hFF);
        // A busy instruction that is a bubble anyway
        drive_instruction(1'b0, read_base + 3, read_base + 6, write_base + 1, 8'h00, 8'hFF);

        // Back-to-back random traffic with bubbles
        // Read flags lean towards full and write flags towards not full
        repeat (random_cycles) begin
            draw_random(r_ctrl);
            draw_random(r_a);
            draw_random(r_b);
            draw_random(r_d);
            draw_random(r_flags);
            drive_instruction(r_ctrl[30] | r_ctrl[29],
                              pick_address(r_a, read_base), pick_address(r_b, read_base),
                              pick_address(r_d, write_base),
                              r_flags[23:16] | r_ctrl[23:16], r_flags[31:24] & r_ctrl[31:24]);
        end

        repeat (drain_cycles) drive_instruction(1'b0, '0, '0, '0, 8'h00, 8'h00);
        @(posedge clock);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("test passed");
        end else begin
            if (check_count == 0) begin
                $display("No output comparisons were made during the run");
            end
            $display("test failed");
        end
        $finish;
    end

    // ----------------------------------------
    // Watchdog
    // ----------------------------------------

    initial begin
        repeat (test_cycles + 20) @(posedge clock);
        $display("Watchdog expired after %0d cycles before the test finished", test_cycles + 20);
        $display("test failed");
        $finish;
    end

endmodule

/* sources.f */
+incdir+.
io_pred_pkg.sv
io_port_check.sv
io_read_predication.sv
io_write_predication.sv
io_ready_combiner.sv
io_predication_top.sv
io_predication_props.sv
io_predication_checker.sv
io_predication_tb.sv
